// ==== byte_buffer.sv ====
module byte_buffer #(
    parameter int RAM_LATENCY = 2,
    parameter int BUF_DEPTH   = 8
) (
    input  logic                clk,
    input  logic                rst,
    input  logic                push,
    input  ram_pkg::lane_byte_t push_data,
    output logic                room,
    output logic                buf_valid,
    output frame_pkg::byte_t    buf_data,
    input  logic                pop
);

    localparam int PTR_W = $clog2(BUF_DEPTH);
    localparam int CNT_W = $clog2(BUF_DEPTH + 1);

    frame_pkg::byte_t  mem [BUF_DEPTH];
    logic [PTR_W-1:0]  wr_ptr;
    logic [PTR_W-1:0]  rd_ptr;
    logic [CNT_W-1:0]  count;
    logic              do_pop;

    assign do_pop    = pop && buf_valid;
    assign buf_valid = (count != '0);
    assign buf_data  = mem[rd_ptr];

    // Keep enough free slots for every read still in flight.
    assign room = (CNT_W'(BUF_DEPTH) - count) > CNT_W'(RAM_LATENCY);

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push) begin
                if (wr_ptr == PTR_W'(BUF_DEPTH - 1)) begin
                    wr_ptr <= '0;
                end else begin
                    wr_ptr <= wr_ptr + 1'b1;
                end
            end
            if (do_pop) begin
                if (rd_ptr == PTR_W'(BUF_DEPTH - 1)) begin
                    rd_ptr <= '0;
                end else begin
                    rd_ptr <= rd_ptr + 1'b1;
                end
            end
            if (push && !do_pop) begin
                count <= count + 1'b1;
            end else if (!push && do_pop) begin
                count <= count - 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (push) begin
            mem[wr_ptr] <= push_data;
        end
    end

endmodule

// ==== frame_packer.sv ====
module frame_packer (
    input  logic                clk,
    input  logic                rst,
    input  logic                fs,
    output logic                fd,
    input  ram_pkg::lane_mask_t link,
    output logic                read_req,
    input  logic                read_ack,
    input  logic                buf_valid,
    input  frame_pkg::byte_t    buf_data,
    output logic                pop,
    input  logic                fifo_full,
    output frame_pkg::byte_t    fifo_txd,
    output logic                fifo_txen
);

    frame_pkg::packer_state_t state;
    ram_pkg::lane_mask_t      link_q;
    frame_pkg::csum_t         csum;

    assign fd  = (state == frame_pkg::ST_DONE);
    assign pop = (state == frame_pkg::ST_DATA) && buf_valid && !fifo_full;

    // A byte goes out in every byte state unless the FIFO is full.
    always_comb begin
        fifo_txd  = '0;
        fifo_txen = 1'b0;
        case (state)
            frame_pkg::ST_HDR0: begin
                fifo_txd  = frame_pkg::HDR_0;
                fifo_txen = !fifo_full;
            end
            frame_pkg::ST_HDR1: begin
                fifo_txd  = frame_pkg::HDR_1;
                fifo_txen = !fifo_full;
            end
            frame_pkg::ST_LINK0: begin
                fifo_txen = !fifo_full;
            end
            frame_pkg::ST_LINK: begin
                fifo_txd  = link_q;
                fifo_txen = !fifo_full;
            end
            frame_pkg::ST_DATA: begin
                fifo_txd  = buf_data;
                fifo_txen = pop;
            end
            frame_pkg::ST_CSUM_HI: begin
                fifo_txd  = csum[15:8];
                fifo_txen = !fifo_full;
            end
            frame_pkg::ST_CSUM_LO: begin
                fifo_txd  = csum[7:0];
                fifo_txen = !fifo_full;
            end
            default: begin
                fifo_txd  = '0;
                fifo_txen = 1'b0;
            end
        endcase
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state    <= frame_pkg::ST_IDLE;
            read_req <= 1'b0;
        end else begin
            case (state)
                frame_pkg::ST_IDLE: begin
                    if (fs) state <= frame_pkg::ST_HDR0;
                end
                frame_pkg::ST_HDR0: begin
                    if (!fifo_full) state <= frame_pkg::ST_HDR1;
                end
                frame_pkg::ST_HDR1: begin
                    if (!fifo_full) state <= frame_pkg::ST_LINK0;
                end
                frame_pkg::ST_LINK0: begin
                    if (!fifo_full) state <= frame_pkg::ST_LINK;
                end
                frame_pkg::ST_LINK: begin
                    if (!fifo_full) begin
                        state    <= frame_pkg::ST_DATA;
                        read_req <= 1'b1;
                    end
                end
                frame_pkg::ST_DATA: begin
                    // Reader is finished and nothing is left to pop.
                    if (!fifo_full && read_ack && !buf_valid) begin
                        state    <= frame_pkg::ST_CSUM_HI;
                        read_req <= 1'b0;
                    end
                end
                frame_pkg::ST_CSUM_HI: begin
                    if (!fifo_full) state <= frame_pkg::ST_CSUM_LO;
                end
                frame_pkg::ST_CSUM_LO: begin
                    if (!fifo_full) state <= frame_pkg::ST_DONE;
                end
                frame_pkg::ST_DONE: begin
                    if (!fs) state <= frame_pkg::ST_IDLE;
                end
                default: state <= frame_pkg::ST_IDLE;
            endcase
        end
    end

    // Link mask and a cleared checksum are loaded on every idle cycle.
    always_ff @(posedge clk) begin
        if (state == frame_pkg::ST_IDLE) begin
            link_q <= link;
            csum   <= '0;
        end else if (pop) begin
            csum <= csum + frame_pkg::csum_t'(buf_data);
        end
    end

endmodule

// ==== frame_pkg.sv ====
package frame_pkg;

    // One byte written to the output FIFO.
    typedef logic [7:0] byte_t;

    // Number of bytes read from each enabled lane.
    typedef logic [11:0] len_t;

    // Running checksum over the data bytes.
    typedef logic [15:0] csum_t;

    // Frame header.
    localparam byte_t HDR_0 = 8'h55;
    localparam byte_t HDR_1 = 8'hAA;

    typedef enum logic [3:0] {
        ST_IDLE,
        ST_HDR0,
        ST_HDR1,
        ST_LINK0,
        ST_LINK,
        ST_DATA,
        ST_CSUM_HI,
        ST_CSUM_LO,
        ST_DONE
    } packer_state_t;

endpackage

// ==== lane_reader.sv ====
module lane_reader #(
    parameter int RAM_LATENCY = 2
) (
    input  logic                                         clk,
    input  logic                                         rst,
    input  logic                                         read_req,
    output logic                                         read_ack,
    input  ram_pkg::lane_mask_t                          link,
    input  frame_pkg::len_t                              data_len,
    input  ram_pkg::addr_t                               ram_rxa_init,
    output ram_pkg::addr_t     [ram_pkg::NUM_LANES-1:0]  ram_rxa,
    input  ram_pkg::lane_byte_t [ram_pkg::NUM_LANES-1:0] ram_rxd,
    input  logic                                         room,
    output logic                                         push,
    output ram_pkg::lane_byte_t                          push_data
);

    localparam int LANE_W = $clog2(ram_pkg::NUM_LANES);

    logic                busy;
    logic                active;
    logic [LANE_W-1:0]   lane_idx;
    frame_pkg::len_t     cnt;
    frame_pkg::len_t     len_q;
    ram_pkg::lane_mask_t link_q;
    ram_pkg::addr_t      addr_q;
    ram_pkg::addr_t      init_q;
    logic                start;
    logic                lane_busy;
    logic                issue;

    // Valid bit and lane index of every read still in flight.
    logic [RAM_LATENCY-1:0] pipe_v;
    logic [LANE_W-1:0]      pipe_lane [RAM_LATENCY];

    assign start     = read_req && !busy && !read_ack;
    assign lane_busy = link_q[lane_idx] && (cnt != len_q);
    assign issue     = active && lane_busy && room;

    // Only the lane being read moves its address.
    always_comb begin
        for (int i = 0; i < ram_pkg::NUM_LANES; i++) begin
            if (active && lane_idx == LANE_W'(i)) begin
                ram_rxa[ram_pkg::NUM_LANES-1-i] = addr_q;
            end else begin
                ram_rxa[ram_pkg::NUM_LANES-1-i] = init_q;
            end
        end
    end

    assign push      = pipe_v[RAM_LATENCY-1];
    assign push_data = ram_rxd[ram_pkg::NUM_LANES-1-pipe_lane[RAM_LATENCY-1]];

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            busy     <= 1'b0;
            active   <= 1'b0;
            read_ack <= 1'b0;
            lane_idx <= '0;
            cnt      <= '0;
            len_q    <= '0;
            link_q   <= '0;
            addr_q   <= '0;
            init_q   <= '0;
            pipe_v   <= '0;
        end else begin
            if (start) begin
                busy     <= 1'b1;
                active   <= 1'b1;
                lane_idx <= '0;
                cnt      <= '0;
                len_q    <= data_len;
                link_q   <= link;
                addr_q   <= ram_rxa_init;
                init_q   <= ram_rxa_init;
            end else if (active) begin
                if (lane_busy) begin
                    if (room) begin
                        addr_q <= addr_q + 1'b1;
                        cnt    <= cnt + 1'b1;
                    end
                end else if (lane_idx == LANE_W'(ram_pkg::NUM_LANES - 1)) begin
                    active <= 1'b0;
                end else begin
                    lane_idx <= lane_idx + 1'b1;
                    cnt      <= '0;
                    addr_q   <= init_q;
                end
            end

            // Acknowledge once every issued byte has been pushed.
            if (busy && !active && pipe_v == '0) begin
                busy     <= 1'b0;
                read_ack <= 1'b1;
            end else if (read_ack && !read_req) begin
                read_ack <= 1'b0;
            end

            pipe_v[0] <= issue;
            for (int k = 1; k < RAM_LATENCY; k++) begin
                pipe_v[k] <= pipe_v[k-1];
            end
        end
    end

    always_ff @(posedge clk) begin
        pipe_lane[0] <= lane_idx;
        for (int k = 1; k < RAM_LATENCY; k++) begin
            pipe_lane[k] <= pipe_lane[k-1];
        end
    end

endmodule

// ==== project.f ====
ram_pkg.sv
frame_pkg.sv
lane_reader.sv
byte_buffer.sv
frame_packer.sv
ram2fifo_top.sv
ram2fifo_props.sv
tb_ram2fifo.sv

// ==== ram2fifo_props.sv ====
module ram2fifo_props (
    input logic clk,
    input logic rst,
    input logic fs,
    input logic fd,
    input logic fifo_full,
    input logic fifo_txen
);

    // The FIFO is never written while it reports full.
    a_txen_not_full: assert property (@(posedge clk) disable iff (rst)
        fifo_full |-> !fifo_txen)
        else $error("fifo_txen was high while fifo_full was high");

    // Once done, fd holds for as long as fs stays high.
    a_fd_hold: assert property (@(posedge clk) disable iff (rst)
        (fd && fs) |=> fd)
        else $error("fd fell while fs was still high");

    // Nothing is written once the frame is done.
    a_no_txen_when_done: assert property (@(posedge clk) disable iff (rst)
        fd |-> !fifo_txen)
        else $error("fifo_txen was high while fd was high");

endmodule

bind ram2fifo_top ram2fifo_props u_props (
    .clk       (clk),
    .rst       (rst),
    .fs        (fs),
    .fd        (fd),
    .fifo_full (fifo_full),
    .fifo_txen (fifo_txen)
);

// ==== ram2fifo_top.sv ====
module ram2fifo_top #(
    parameter int RAM_LATENCY = 2,
    parameter int BUF_DEPTH   = 8
) (
    input  logic                                         clk,
    input  logic                                         rst,
    input  logic                                         fs,
    output logic                                         fd,
    input  ram_pkg::addr_t                               ram_rxa_init,
    input  frame_pkg::len_t                              data_len,
    input  ram_pkg::lane_mask_t                          link,
    input  ram_pkg::lane_byte_t [ram_pkg::NUM_LANES-1:0] ram_rxd,
    output ram_pkg::addr_t     [ram_pkg::NUM_LANES-1:0]  ram_rxa,
    input  logic                                         fifo_full,
    output frame_pkg::byte_t                             fifo_txd,
    output logic                                         fifo_txen
);

    logic                read_req;
    logic                read_ack;
    logic                room;
    logic                push;
    ram_pkg::lane_byte_t push_data;
    logic                buf_valid;
    frame_pkg::byte_t    buf_data;
    logic                pop;

    lane_reader #(
        .RAM_LATENCY (RAM_LATENCY)
    ) u_reader (
        .clk          (clk),
        .rst          (rst),
        .read_req     (read_req),
        .read_ack     (read_ack),
        .link         (link),
        .data_len     (data_len),
        .ram_rxa_init (ram_rxa_init),
        .ram_rxa      (ram_rxa),
        .ram_rxd      (ram_rxd),
        .room         (room),
        .push         (push),
        .push_data    (push_data)
    );

    byte_buffer #(
        .RAM_LATENCY (RAM_LATENCY),
        .BUF_DEPTH   (BUF_DEPTH)
    ) u_buffer (
        .clk       (clk),
        .rst       (rst),
        .push      (push),
        .push_data (push_data),
        .room      (room),
        .buf_valid (buf_valid),
        .buf_data  (buf_data),
        .pop       (pop)
    );

    frame_packer u_packer (
        .clk       (clk),
        .rst       (rst),
        .fs        (fs),
        .fd        (fd),
        .link      (link),
        .read_req  (read_req),
        .read_ack  (read_ack),
        .buf_valid (buf_valid),
        .buf_data  (buf_data),
        .pop       (pop),
        .fifo_full (fifo_full),
        .fifo_txd  (fifo_txd),
        .fifo_txen (fifo_txen)
    );

endmodule

// ==== ram_pkg.sv ====
package ram_pkg;

    // Number of RAM lanes read into one frame.
    localparam int NUM_LANES = 8;

    // Address of one lane RAM.
    typedef logic [11:0] addr_t;

    // One byte returned by a lane RAM.
    typedef logic [7:0] lane_byte_t;

    // Lane enable mask with bit i enabling lane i.
    typedef logic [NUM_LANES-1:0] lane_mask_t;

endpackage

// ==== run.sh ====
#!/usr/bin/env bash
# Builds the testbench with Verilator and runs it from the project root.
cd "$(dirname "$0")" || exit 1

verilator --binary --assert -Wno-fatal --top-module tb_ram2fifo -f project.f \
    && ./obj_dir/Vtb_ram2fifo \
    || { echo "simulation did not complete cleanly"; exit 1; }

// ==== tb_ram2fifo.sv ====
module tb_ram2fifo;

    localparam int RAM_LATENCY  = 2;
    localparam int BUF_DEPTH    = 8;
    localparam int NUM_FRAMES   = 12;
    localparam int MAX_LEN      = 20;
    localparam int CLK_PERIOD   = 4;
    localparam int RESET_CYCLES = 8;
    localparam int LIMIT_CYCLES = RESET_CYCLES
        + NUM_FRAMES * (ram_pkg::NUM_LANES * MAX_LEN + 20) * 4;

    logic                                         clk;
    logic                                         rst;
    logic                                         fs;
    logic                                         fd;
    ram_pkg::addr_t                               ram_rxa_init;
    frame_pkg::len_t                              data_len;
    ram_pkg::lane_mask_t                          link;
    ram_pkg::lane_byte_t [ram_pkg::NUM_LANES-1:0] ram_rxd;
    ram_pkg::addr_t      [ram_pkg::NUM_LANES-1:0] ram_rxa;
    logic                                         fifo_full;
    frame_pkg::byte_t                             fifo_txd;
    logic                                         fifo_txen;

    // Addresses seen by the RAMs, delayed by the read latency.
    ram_pkg::addr_t [ram_pkg::NUM_LANES-1:0] addr_pipe [RAM_LATENCY];

    logic [31:0]      lfsr_state;
    frame_pkg::byte_t exp_q [$];
    string            tag_q [$];
    int               rx_count = 0;

    ram2fifo_top #(
        .RAM_LATENCY (RAM_LATENCY),
        .BUF_DEPTH   (BUF_DEPTH)
    ) DUT (
        .clk          (clk),
        .rst          (rst),
        .fs           (fs),
        .fd           (fd),
        .ram_rxa_init (ram_rxa_init),
        .data_len     (data_len),
        .link         (link),
        .ram_rxd      (ram_rxd),
        .ram_rxa      (ram_rxa),
        .fifo_full    (fifo_full),
        .fifo_txd     (fifo_txd),
        .fifo_txen    (fifo_txen)
    );

    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int b = 0; b < n; b++) begin
            lfsr_state = lfsr_step(lfsr_state);
            v = {v[30:0], lfsr_state[0]};
        end
        return v;
    endfunction

    // Content of lane RAM at one address.
    function automatic ram_pkg::lane_byte_t ram_byte(input int lane, input ram_pkg::addr_t addr);
        logic [15:0] mix;
        mix = {4'h0, addr} * 16'd157 + 16'(lane) * 16'd77;
        return mix[7:0] ^ mix[15:8];
    endfunction

    task automatic stop_with_error(input string msg);
        $display("%s", msg);
        $display("ERRORS FOUND");
        $fatal(1);
    endtask

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        if (expected !== actual) begin
            stop_with_error($sformatf("MISMATCH %s expected %0h actual %0h",
                                      name, expected, actual));
        end
    endtask

    task automatic expect_byte(input frame_pkg::byte_t value, input string tag);
        exp_q.push_back(value);
        tag_q.push_back(tag);
    endtask

    task automatic next_cycle();
        @(posedge clk);
        fifo_full <= (rand_bits(2) == 32'd3);
    endtask

    task automatic run_frame(input int idx);
        ram_pkg::lane_mask_t f_link;
        frame_pkg::len_t     f_len;
        ram_pkg::addr_t      f_init;
        frame_pkg::csum_t    sum;
        frame_pkg::byte_t    b;
        int                  start_count;
        int                  hold;

        f_link = ram_pkg::lane_mask_t'(rand_bits(8));
        f_len  = frame_pkg::len_t'(rand_bits(5) % (MAX_LEN + 1));
        f_init = ram_pkg::addr_t'(rand_bits(12));
        // First frames cover all lanes, no lanes and empty lanes.
        if (idx == 0) begin
            f_link = 8'hFF;
            f_len  = frame_pkg::len_t'(MAX_LEN);
        end else if (idx == 1) begin
            f_link = 8'h00;
        end else if (idx == 2) begin
            f_len = '0;
        end

        sum = '0;
        expect_byte(frame_pkg::HDR_0, $sformatf("frame %0d header 0", idx));
        expect_byte(frame_pkg::HDR_1, $sformatf("frame %0d header 1", idx));
        expect_byte(8'h00, $sformatf("frame %0d link zero", idx));
        expect_byte(f_link, $sformatf("frame %0d link", idx));
        for (int lane = 0; lane < ram_pkg::NUM_LANES; lane++) begin
            for (int k = 0; k < int'(f_len) && f_link[lane]; k++) begin
                b   = ram_byte(lane, ram_pkg::addr_t'(f_init + k));
                sum = sum + frame_pkg::csum_t'(b);
                expect_byte(b, $sformatf("frame %0d lane %0d byte %0d", idx, lane, k));
            end
        end
        expect_byte(sum[15:8], $sformatf("frame %0d checksum high", idx));
        expect_byte(sum[7:0], $sformatf("frame %0d checksum low", idx));

        start_count  = rx_count;
        link         <= f_link;
        data_len     <= f_len;
        ram_rxa_init <= f_init;
        fs           <= 1'b1;
        do next_cycle(); while (!fd);

        check_value($sformatf("frame %0d byte count", idx),
                    6 + int'(f_len) * $countones(f_link), rx_count - start_count);
        check_value($sformatf("frame %0d bytes left", idx), 0, exp_q.size());

        hold = int'(rand_bits(2));
        repeat (hold) begin
            next_cycle();
            check_value($sformatf("frame %0d fd hold", idx), 1, fd);
        end
        fs <= 1'b0;
        do next_cycle(); while (fd);
    endtask

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    // RAM model whose data follows the address by RAM_LATENCY cycles.
    initial begin
        for (int s = 0; s < RAM_LATENCY; s++) begin
            addr_pipe[s] <= '0;
        end
        forever begin
            @(posedge clk);
            addr_pipe[0] <= ram_rxa;
            for (int s = 1; s < RAM_LATENCY; s++) begin
                addr_pipe[s] <= addr_pipe[s-1];
            end
        end
    end

    always_comb begin
        for (int i = 0; i < ram_pkg::NUM_LANES; i++) begin
            ram_rxd[ram_pkg::NUM_LANES-1-i] =
                ram_byte(i, addr_pipe[RAM_LATENCY-1][ram_pkg::NUM_LANES-1-i]);
        end
    end

    always @(posedge clk) begin
        if (!rst && fifo_txen) begin
            if (fifo_full) begin
                stop_with_error("A byte was written while the FIFO was full.");
            end else if (exp_q.size() == 0) begin
                stop_with_error("A byte was written when no byte was expected.");
            end else begin
                check_value(tag_q.pop_front(), 32'(exp_q.pop_front()), 32'(fifo_txd));
                rx_count++;
            end
        end
    end

    initial begin
        #(LIMIT_CYCLES * CLK_PERIOD);
        stop_with_error("Timeout: the frames did not complete within the time limit.");
    end

    initial begin
        rst          = 1'b1;
        fs           = 1'b0;
        link         = '0;
        data_len     = '0;
        ram_rxa_init = '0;
        fifo_full    = 1'b0;
        lfsr_state   = 32'h718feffe;
        repeat (RESET_CYCLES) @(posedge clk);
        rst <= 1'b0;
        repeat (2) next_cycle();
        for (int f = 0; f < NUM_FRAMES; f++) begin
            run_frame(f);
        end
        repeat (4) next_cycle();
        $display("NO ERRORS");
        $finish;
    end

endmodule
